// File: rtl/div_op_pkg.sv
`default_nettype none

package div_op_pkg;

  // ============================================================
  // one-hot operation codes, one bit per RV64M divide op
  // ============================================================
  typedef logic [7:0] op_t;

  localparam op_t OP_DIV   = 8'b1000_0000; // signed, 64-bit
  localparam op_t OP_DIVU  = 8'b0100_0000; // unsigned, 64-bit
  localparam op_t OP_DIVUW = 8'b0010_0000; // unsigned, word
  localparam op_t OP_DIVW  = 8'b0001_0000; // signed, word
  localparam op_t OP_REM   = 8'b0000_1000; // signed, 64-bit
  localparam op_t OP_REMU  = 8'b0000_0100; // unsigned, 64-bit
  localparam op_t OP_REMUW = 8'b0000_0010; // unsigned, word
  localparam op_t OP_REMW  = 8'b0000_0001; // signed, word

  // divide core FSM
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    HOLD
  } state_e;

  // ============================================================
  // operation class decode
  // ============================================================
  function automatic logic op_is_signed(input op_t op);
    return |(op & (OP_DIV | OP_DIVW | OP_REM | OP_REMW));
  endfunction

  function automatic logic op_is_word(input op_t op);
    return |(op & (OP_DIVUW | OP_DIVW | OP_REMUW | OP_REMW));
  endfunction

  function automatic logic op_is_rem(input op_t op);
    return |(op & (OP_REM | OP_REMU | OP_REMUW | OP_REMW));
  endfunction

endpackage

`default_nettype wire

// File: rtl/div_data_pkg.sv
`default_nettype none

package div_data_pkg;

  // ============================================================
  // data widths
  // ============================================================
  localparam int XLEN = 64;
  localparam int WLEN = 32; // word ops

  typedef logic [XLEN-1:0]   xlen_t; // operand, quotient, remainder
  typedef logic [WLEN-1:0]   word_t;
  typedef logic [2*XLEN-1:0] wide_t; // {remainder, quotient}
  typedef logic [6:0]        iter_t; // holds up to 64

  // iteration counts per operand width
  localparam iter_t ITER_D = iter_t'(XLEN);
  localparam iter_t ITER_W = iter_t'(WLEN);

  // most-negative values for the overflow check
  localparam xlen_t INT_MIN   = {1'b1, {(XLEN-1){1'b0}}};
  localparam word_t INT_MIN_W = {1'b1, {(WLEN-1){1'b0}}};

endpackage

`default_nettype wire

// File: rtl/div_operand_prep.sv
`timescale 1ns/1ns
`default_nettype none

module div_operand_prep (
  input  div_op_pkg::op_t     op_i,
  input  div_data_pkg::xlen_t dividend_i,
  input  div_data_pkg::xlen_t divisor_i,
  output logic                op_ok_o,
  output logic                excp_o,
  output div_data_pkg::xlen_t excp_value_o,
  output div_data_pkg::xlen_t init_o,
  output div_data_pkg::xlen_t divisor_o,
  output div_data_pkg::iter_t iter_o,
  output logic                q_neg_o,
  output logic                r_neg_o
);

  logic                is_signed;
  logic                is_word;
  logic                is_rem;
  div_data_pkg::word_t dvd_lo;
  div_data_pkg::word_t dvs_lo;
  div_data_pkg::xlen_t dvd_sext;
  div_data_pkg::xlen_t dvs_sext;
  div_data_pkg::xlen_t dvd_src;
  div_data_pkg::xlen_t dvs_src;
  div_data_pkg::xlen_t dvd_abs;
  div_data_pkg::xlen_t dvs_abs;
  div_data_pkg::xlen_t dvd_res;
  logic                dvd_neg;
  logic                dvs_neg;
  logic                div_zero;
  logic                div_of;

  // ============================================================
  // operation class
  // ============================================================
  assign is_signed = div_op_pkg::op_is_signed(op_i);
  assign is_word   = div_op_pkg::op_is_word(op_i);
  assign is_rem    = div_op_pkg::op_is_rem(op_i);
  assign op_ok_o   = $onehot(op_i); // any one-hot code is a valid op

  // ============================================================
  // operand forming
  // ============================================================
  assign dvd_lo   = dividend_i[31:0];
  assign dvs_lo   = divisor_i[31:0];
  assign dvd_sext = {{32{dvd_lo[31]}}, dvd_lo};
  assign dvs_sext = {{32{dvs_lo[31]}}, dvs_lo};

  // unsigned word ops see zero-extended operands
  assign dvd_src = !is_word ? dividend_i : (is_signed ? dvd_sext : {32'd0, dvd_lo});
  assign dvs_src = !is_word ? divisor_i  : (is_signed ? dvs_sext : {32'd0, dvs_lo});

  assign dvd_neg = is_signed & dvd_src[63];
  assign dvs_neg = is_signed & dvs_src[63];

  assign dvd_abs = dvd_neg ? (~dvd_src + 64'd1) : dvd_src; // two's complement
  assign dvs_abs = dvs_neg ? (~dvs_src + 64'd1) : dvs_src;

  // word dividend sits in the top half so 32 shifts consume it
  assign init_o    = is_word ? {dvd_abs[31:0], 32'd0} : dvd_abs;
  assign divisor_o = dvs_abs;
  assign iter_o    = is_word ? div_data_pkg::ITER_W : div_data_pkg::ITER_D;

  assign q_neg_o = dvd_neg ^ dvs_neg;
  assign r_neg_o = dvd_neg; // remainder follows the dividend

  // ============================================================
  // divide-by-zero and signed overflow
  // ============================================================
  assign div_zero = is_word ? (dvs_lo == '0) : (divisor_i == '0);

  assign div_of = is_signed &
                  (is_word ? ((dvd_lo == div_data_pkg::INT_MIN_W) && (&dvs_lo))
                           : ((dividend_i == div_data_pkg::INT_MIN) && (&divisor_i)));

  assign excp_o  = op_ok_o & (div_zero | div_of);
  assign dvd_res = is_word ? dvd_sext : dividend_i;

  always_comb begin
    if (div_zero) begin
      excp_value_o = is_rem ? dvd_res : '1; // all ones for divides
    end else if (div_of) begin
      excp_value_o = is_rem ? '0 : dvd_res;
    end else begin
      excp_value_o = '0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/div_restoring_core.sv
`timescale 1ns/1ns
`default_nettype none

module div_restoring_core (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start_i,
  input  logic                op_ok_i,
  input  logic                excp_i,
  input  div_data_pkg::xlen_t excp_value_i,
  input  div_data_pkg::xlen_t init_i,
  input  div_data_pkg::xlen_t divisor_i,
  input  div_data_pkg::iter_t iter_i,
  input  logic                q_neg_i,
  input  logic                r_neg_i,
  input  div_op_pkg::op_t     op_i,
  input  logic                ready_i,
  output div_data_pkg::xlen_t quotient_o,
  output div_data_pkg::xlen_t remainder_o,
  output logic                q_neg_o,
  output logic                r_neg_o,
  output div_op_pkg::op_t     op_o,
  output logic                excp_o,
  output logic                busy_o,
  output logic                done_o
);

  div_op_pkg::state_e  state_q;
  div_op_pkg::state_e  state_d;
  div_data_pkg::iter_t cnt_q;
  div_data_pkg::iter_t cnt_d;
  div_op_pkg::op_t     op_q;
  div_op_pkg::op_t     op_d;
  logic                q_neg_q;
  logic                q_neg_d;
  logic                r_neg_q;
  logic                r_neg_d;
  logic                excp_q;
  logic                excp_d;
  div_data_pkg::wide_t acc_q;
  div_data_pkg::wide_t acc_d;
  div_data_pkg::xlen_t dvs_q;
  div_data_pkg::xlen_t dvs_d;
  logic [64:0]         part; // shifted remainder with carry bit
  logic [64:0]         diff; // top bit set on borrow
  logic                accept;

  // ============================================================
  // shift-subtract step
  // ============================================================
  assign part   = acc_q[127:63];
  assign diff   = part - {1'b0, dvs_q};
  assign accept = (state_q == div_op_pkg::IDLE) & start_i & op_ok_i;

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    op_d    = op_q;
    q_neg_d = q_neg_q;
    r_neg_d = r_neg_q;
    excp_d  = excp_q;
    acc_d   = acc_q;
    dvs_d   = dvs_q;
    case (state_q)
      div_op_pkg::IDLE: begin
        if (accept) begin
          op_d    = op_i;
          q_neg_d = q_neg_i;
          r_neg_d = r_neg_i;
          excp_d  = excp_i;
          if (excp_i) begin
            acc_d   = {64'd0, excp_value_i}; // fixed result without iterations
            state_d = div_op_pkg::HOLD;
          end else begin
            acc_d   = {64'd0, init_i};
            dvs_d   = divisor_i;
            cnt_d   = iter_i;
            state_d = div_op_pkg::RUN;
          end
        end
      end
      div_op_pkg::RUN: begin
        if (cnt_q == '0) begin
          state_d = div_op_pkg::HOLD; // closing cycle
        end else begin
          cnt_d = cnt_q - 7'd1;
          if (diff[64]) begin
            acc_d = {part[63:0], acc_q[62:0], 1'b0}; // restore
          end else begin
            acc_d = {diff[63:0], acc_q[62:0], 1'b1};
          end
        end
      end
      div_op_pkg::HOLD: begin
        if (ready_i) begin
          state_d = div_op_pkg::IDLE;
        end
      end
      default: begin
        state_d = div_op_pkg::IDLE;
      end
    endcase
  end

  // ============================================================
  // registers
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= div_op_pkg::IDLE;
      cnt_q   <= '0;
      op_q    <= '0;
      q_neg_q <= 1'b0;
      r_neg_q <= 1'b0;
      excp_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      op_q    <= op_d;
      q_neg_q <= q_neg_d;
      r_neg_q <= r_neg_d;
      excp_q  <= excp_d;
    end
  end

  always_ff @(posedge clk) begin
    acc_q <= acc_d;
    dvs_q <= dvs_d;
  end

  assign quotient_o  = acc_q[63:0];
  assign remainder_o = acc_q[127:64];
  assign q_neg_o     = q_neg_q;
  assign r_neg_o     = r_neg_q;
  assign op_o        = op_q;
  assign excp_o      = excp_q;
  assign busy_o      = accept | (state_q == div_op_pkg::RUN);
  assign done_o      = (state_q == div_op_pkg::HOLD);

endmodule

`default_nettype wire

// File: rtl/div_result_sel.sv
`timescale 1ns/1ns
`default_nettype none

module div_result_sel (
  input  div_op_pkg::op_t     op_i,
  input  div_data_pkg::xlen_t quotient_i,
  input  div_data_pkg::xlen_t remainder_i,
  input  logic                q_neg_i,
  input  logic                r_neg_i,
  input  logic                excp_i,
  input  logic                done_i,
  output div_data_pkg::xlen_t result_o
);

  div_data_pkg::xlen_t q_fix;
  div_data_pkg::xlen_t r_fix;
  div_data_pkg::xlen_t q_word;
  div_data_pkg::xlen_t r_word;
  div_data_pkg::xlen_t sel;

  // ============================================================
  // sign restore
  // ============================================================
  assign q_fix = q_neg_i ? (~quotient_i + 64'd1) : quotient_i;
  assign r_fix = r_neg_i ? (~remainder_i + 64'd1) : remainder_i;

  // word results take bit 31 as sign
  assign q_word = {{32{q_fix[31]}}, q_fix[31:0]};
  assign r_word = {{32{r_fix[31]}}, r_fix[31:0]};

  // ============================================================
  // lookup keyed by the latched op
  // ============================================================
  always_comb begin
    case (op_i)
      div_op_pkg::OP_DIV:   sel = q_fix;
      div_op_pkg::OP_DIVU:  sel = q_fix;  // sign flag clear
      div_op_pkg::OP_DIVUW: sel = q_word;
      div_op_pkg::OP_DIVW:  sel = q_word;
      div_op_pkg::OP_REM:   sel = r_fix;
      div_op_pkg::OP_REMU:  sel = r_fix;
      div_op_pkg::OP_REMUW: sel = r_word;
      div_op_pkg::OP_REMW:  sel = r_word;
      default:              sel = '0;
    endcase
  end

  // exception value already sits in the quotient half, final form
  assign result_o = !done_i ? '0 : (excp_i ? quotient_i : sel);

endmodule

`default_nettype wire

// File: rtl/div_unit.sv
`timescale 1ns/1ns
`default_nettype none

module div_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start_i,
  input  div_op_pkg::op_t     op_i,
  input  div_data_pkg::xlen_t dividend_i,
  input  div_data_pkg::xlen_t divisor_i,
  input  logic                ready_i,
  output div_data_pkg::xlen_t result_o,
  output logic                busy_o,
  output logic                done_o
);

  // prep to core
  logic                prep_op_ok;
  logic                prep_excp;
  div_data_pkg::xlen_t prep_excp_value;
  div_data_pkg::xlen_t prep_init;
  div_data_pkg::xlen_t prep_divisor;
  div_data_pkg::iter_t prep_iter;
  logic                prep_q_neg;
  logic                prep_r_neg;

  // core to result stage
  div_data_pkg::xlen_t core_quotient;
  div_data_pkg::xlen_t core_remainder;
  logic                core_q_neg;
  logic                core_r_neg;
  div_op_pkg::op_t     core_op;
  logic                core_excp;

  // ============================================================
  // datapath
  // ============================================================
  div_operand_prep u_prep (
    .op_i         (op_i),
    .dividend_i   (dividend_i),
    .divisor_i    (divisor_i),
    .op_ok_o      (prep_op_ok),
    .excp_o       (prep_excp),
    .excp_value_o (prep_excp_value),
    .init_o       (prep_init),
    .divisor_o    (prep_divisor),
    .iter_o       (prep_iter),
    .q_neg_o      (prep_q_neg),
    .r_neg_o      (prep_r_neg)
  );

  div_restoring_core u_core (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start_i),
    .op_ok_i      (prep_op_ok),
    .excp_i       (prep_excp),
    .excp_value_i (prep_excp_value),
    .init_i       (prep_init),
    .divisor_i    (prep_divisor),
    .iter_i       (prep_iter),
    .q_neg_i      (prep_q_neg),
    .r_neg_i      (prep_r_neg),
    .op_i         (op_i),
    .ready_i      (ready_i),
    .quotient_o   (core_quotient),
    .remainder_o  (core_remainder),
    .q_neg_o      (core_q_neg),
    .r_neg_o      (core_r_neg),
    .op_o         (core_op),
    .excp_o       (core_excp),
    .busy_o       (busy_o),
    .done_o       (done_o)
  );

  div_result_sel u_sel (
    .op_i         (core_op),
    .quotient_i   (core_quotient),
    .remainder_i  (core_remainder),
    .q_neg_i      (core_q_neg),
    .r_neg_i      (core_r_neg),
    .excp_i       (core_excp),
    .done_i       (done_o),
    .result_o     (result_o)
  );

endmodule

`default_nettype wire

// File: verif/div_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

module div_unit_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int DONE_TIMEOUT = 100; // cycles from start to done_o

  logic                clk;
  logic                rst_n;
  logic                start_i;
  div_op_pkg::op_t     op_i;
  div_data_pkg::xlen_t dividend_i;
  div_data_pkg::xlen_t divisor_i;
  logic                ready_i;
  div_data_pkg::xlen_t result_o;
  logic                busy_o;
  logic                done_o;

  integer              seed;
  div_op_pkg::op_t     op_list [8];
  logic [63:0]         opa;
  logic [63:0]         opb;
  logic [31:0]         pick;

  div_unit i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (start_i),
    .op_i       (op_i),
    .dividend_i (dividend_i),
    .divisor_i  (divisor_i),
    .ready_i    (ready_i),
    .result_o   (result_o),
    .busy_o     (busy_o),
    .done_o     (done_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // ============================================================
  // helpers
  // ============================================================
  task automatic fail_stop();
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Fail time=%0t %s actual=%h expected=%h", $time, name, actual, expected);
      fail_stop();
    end
  endtask

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  function automatic logic [63:0] sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  // corner values come up often, on purpose
  function automatic logic [63:0] pick_operand();
    logic [31:0] sel;
    logic [31:0] r1;
    logic [31:0] r2;
    sel = next_rand();
    r1  = next_rand();
    r2  = next_rand();
    case (sel[2:0])
      3'd0:    return '0;
      3'd1:    return '1;                       // minus one
      3'd2:    return 64'h8000_0000_0000_0000;  // most negative
      3'd3:    return {60'd0, r1[3:0]};
      3'd4:    return 64'hFFFF_FFFF_8000_0000;  // word most negative
      3'd5:    return {{60{1'b1}}, r1[3:0]};    // small negative
      3'd6:    return {r2, r1};
      default: return {32'd0, r1};
    endcase
  endfunction

  // RV64M result and expected latency in clocks from the start edge
  function automatic void reference_model(input div_op_pkg::op_t op, input logic [63:0] a,
                                          input logic [63:0] b, output logic [63:0] res,
                                          output int lat);
    logic               zero64;
    logic               zero32;
    logic               ovf64;
    logic               ovf32;
    logic               exc;
    logic               word;
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] sq;
    logic signed [63:0] sr;
    logic signed [31:0] wa;
    logic signed [31:0] wb;
    logic signed [31:0] wq;
    logic signed [31:0] wr;
    logic [63:0]        ub;
    logic [31:0]        uwb;
    zero64 = (b == 64'd0);
    zero32 = (b[31:0] == 32'd0);
    ovf64  = (a == 64'h8000_0000_0000_0000) && (b == '1);
    ovf32  = (a[31:0] == 32'h8000_0000) && (b[31:0] == '1);
    sa  = a;
    sb  = (zero64 | ovf64) ? 64'd1 : b;   // keep the host division safe
    sq  = sa / sb;
    sr  = sa % sb;
    wa  = a[31:0];
    wb  = (zero32 | ovf32) ? 32'd1 : b[31:0];
    wq  = wa / wb;
    wr  = wa % wb;
    ub  = zero64 ? 64'd1 : b;
    uwb = zero32 ? 32'd1 : b[31:0];
    exc  = 1'b0;
    word = 1'b0;
    res  = '0;
    case (op)
      div_op_pkg::OP_DIV: begin
        res = zero64 ? '1 : (ovf64 ? a : sq);
        exc = zero64 | ovf64;
      end
      div_op_pkg::OP_REM: begin
        res = zero64 ? a : (ovf64 ? 64'd0 : sr);
        exc = zero64 | ovf64;
      end
      div_op_pkg::OP_DIVU: begin
        res = zero64 ? '1 : (a / ub);
        exc = zero64;
      end
      div_op_pkg::OP_REMU: begin
        res = zero64 ? a : (a % ub);
        exc = zero64;
      end
      div_op_pkg::OP_DIVW: begin
        res  = zero32 ? '1 : (ovf32 ? sext32(a[31:0]) : sext32(wq));
        exc  = zero32 | ovf32;
        word = 1'b1;
      end
      div_op_pkg::OP_REMW: begin
        res  = zero32 ? sext32(a[31:0]) : (ovf32 ? 64'd0 : sext32(wr));
        exc  = zero32 | ovf32;
        word = 1'b1;
      end
      div_op_pkg::OP_DIVUW: begin
        res  = zero32 ? '1 : sext32(a[31:0] / uwb);
        exc  = zero32;
        word = 1'b1;
      end
      div_op_pkg::OP_REMUW: begin
        res  = zero32 ? sext32(a[31:0]) : sext32(a[31:0] % uwb);
        exc  = zero32;
        word = 1'b1;
      end
      default: res = '0;
    endcase
    lat = exc ? 1 : (word ? 34 : 66);
  endfunction

  task automatic drive_stray_start();
    pick       = next_rand();
    op_i       = op_list[pick[2:0]];
    dividend_i = pick_operand();
    divisor_i  = pick_operand();
    start_i    = 1'b1;
  endtask

  // ============================================================
  // one operation with latency, hold and stray starts
  // ============================================================
  task automatic run_op(input div_op_pkg::op_t op, input logic [63:0] a, input logic [63:0] b);
    logic [63:0] exp_res;
    int          exp_lat;
    int          cyc;
    int          hold;
    int          stray;
    logic        seen;
    reference_model(op, a, b, exp_res, exp_lat);
    stray = 2 + int'(next_rand() % 32'd8);
    hold  = int'(next_rand() % 32'd8);
    @(negedge clk);
    op_i       = op;
    dividend_i = a;
    divisor_i  = b;
    start_i    = 1'b1;
    ready_i    = 1'b0;
    #10;
    check_value("busy_o", 64'(busy_o), 64'd1); // high in the start cycle
    cyc  = 0;
    seen = 1'b0;
    while (!seen) begin
      @(posedge clk);
      cyc++;
      @(negedge clk);
      if (done_o) seen = 1'b1;
      else check_value("busy_o", 64'(busy_o), 64'd1);
      start_i = 1'b0;
      if (!seen && cyc == stray) drive_stray_start(); // must be ignored in RUN
      if (!seen && cyc >= DONE_TIMEOUT) begin
        $display("timeout at %0t: done_o did not rise after start", $time);
        fail_stop();
      end
    end
    check_value("done_o latency", 64'(cyc), 64'(exp_lat));
    check_value("busy_o", 64'(busy_o), 64'd0);
    for (int i = 0; i <= hold; i++) begin
      check_value("done_o", 64'(done_o), 64'd1);
      check_value("result_o", result_o, exp_res);
      if (i < hold) begin
        if (next_rand() % 32'd3 == 32'd0) drive_stray_start();
        else start_i = 1'b0;
      end else begin
        start_i = 1'b0;
        ready_i = 1'b1;
      end
      @(negedge clk);
    end
    ready_i = 1'b0;
    check_value("done_o", 64'(done_o), 64'd0);
    check_value("busy_o", 64'(busy_o), 64'd0);
    check_value("result_o", result_o, 64'd0);
  endtask

  task automatic run_bad_op();
    logic [31:0]     r;
    div_op_pkg::op_t bad;
    r   = next_rand();
    bad = r[7:0];
    if (bad != 8'd0 && (bad & (bad - 8'd1)) == 8'd0) begin
      bad = bad | ((bad == 8'h01) ? 8'h02 : 8'h01); // force a second bit
    end
    @(negedge clk);
    op_i       = bad;
    dividend_i = pick_operand();
    divisor_i  = pick_operand();
    start_i    = 1'b1;
    #10;
    check_value("busy_o", 64'(busy_o), 64'd0);
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      check_value("busy_o", 64'(busy_o), 64'd0);
      check_value("done_o", 64'(done_o), 64'd0);
      check_value("result_o", result_o, 64'd0);
      start_i = 1'b0;
    end
  endtask

  // ============================================================
  // main sequence
  // ============================================================
  initial begin
    seed    = 22368;
    op_list = '{div_op_pkg::OP_DIV, div_op_pkg::OP_DIVU, div_op_pkg::OP_DIVUW,
                div_op_pkg::OP_DIVW, div_op_pkg::OP_REM, div_op_pkg::OP_REMU,
                div_op_pkg::OP_REMUW, div_op_pkg::OP_REMW};
    rst_n      = 1'b1; // active high
    start_i    = 1'b0;
    op_i       = '0;
    dividend_i = '0;
    divisor_i  = '0;
    ready_i    = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b0;
    check_value("busy_o", 64'(busy_o), 64'd0);
    check_value("done_o", 64'(done_o), 64'd0);
    check_value("result_o", result_o, 64'd0);

    // divide by zero on every code, then the overflow pairs
    for (int i = 0; i < 8; i++) begin
      opa = pick_operand();
      run_op(op_list[i], opa, 64'd0);
    end
    run_op(div_op_pkg::OP_DIVUW, 64'h1234_5678_9ABC_DEF0, 64'hFFFF_0000_0000_0000);
    run_op(div_op_pkg::OP_DIV, 64'h8000_0000_0000_0000, '1);
    run_op(div_op_pkg::OP_REM, 64'h8000_0000_0000_0000, '1);
    run_op(div_op_pkg::OP_DIVW, 64'h0000_00A5_8000_0000, 64'h0000_0001_FFFF_FFFF);
    run_op(div_op_pkg::OP_REMW, 64'h0000_00A5_8000_0000, 64'h0000_0001_FFFF_FFFF);

    for (int n = 0; n < 400; n++) begin
      pick = next_rand();
      if (pick[7:4] == 4'd0) begin
        run_bad_op();
      end else begin
        opa = pick_operand();
        opb = pick_operand();
        run_op(op_list[pick[2:0]], opa, opb);
      end
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: div_unit.f
rtl/div_op_pkg.sv
rtl/div_data_pkg.sv
rtl/div_operand_prep.sv
rtl/div_restoring_core.sv
rtl/div_result_sel.sv
rtl/div_unit.sv
verif/div_unit_tb.sv

// File: Makefile
# Verilator build and run of the divide unit testbench

VERILATOR ?= verilator
TB_TOP    ?= div_unit_tb
RTL_TOP   ?= div_unit
FILELIST  ?= div_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
